// File: flist.f
+incdir+include
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_core.sv
tb/tb_rv_core.sv

// File: hw/rv_core.sv
`timescale 1ns/10ps
`include "core_config.svh"

module rv_core (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic [31:0]           i_instr,
    input  logic                  i_if_valid,
    input  logic [`CORE_XLEN-1:0] i_data_in,
    input  logic                  i_mem_ready,
    output logic [`CORE_XLEN-1:0] o_pc,
    output logic [`CORE_XLEN-1:0] o_data_addr,
    output logic [`CORE_XLEN-1:0] o_data_out,
    output logic                  o_store_req,
    output logic                  o_load_req
);
    import rv_pkg::*;

    // Fetch buffer
    logic [`CORE_XLEN-1:0]   pc_q, f_pc;
    logic [31:0]             instr_q;
    logic                    f_valid;
    logic [`CORE_REG_AW-1:0] f_rs1, f_rs2, f_rd;

    // Decode outputs
    logic [`CORE_XLEN-1:0] dec_imm;
    alu_op_e               dec_alu_op;
    src_a_e                dec_src_a;
    src_b_e                dec_src_b;
    logic dec_reg_w, dec_mem_w, dec_mem2reg, dec_branch, dec_jump, dec_illegal;

    // Register file
    logic [`CORE_REG_AW-1:0] rf_rs1_addr, rf_rs2_addr;
    logic [`CORE_XLEN-1:0]   rf_rs1, rf_rs2;

    // Execute stage
    logic                    ex_valid;
    logic [`CORE_XLEN-1:0]   ex_pc, ex_imm, ex_rs1, ex_rs2;
    logic [`CORE_REG_AW-1:0] ex_rs1_addr, ex_rs2_addr, ex_rd;
    alu_op_e                 ex_alu_op;
    src_a_e                  ex_src_a;
    src_b_e                  ex_src_b;
    logic ex_reg_w, ex_mem_w, ex_mem2reg, ex_branch, ex_jump, ex_jalr;
    logic [`CORE_XLEN-1:0]   ex_alu_out, ex_store_data, ex_target;
    logic                    ex_taken;
    fwd_sel_e                fwd_rs1, fwd_rs2;

    // Memory and writeback stages
    logic                    mem_valid, mem_reg_w, mem_mem_w, mem_mem2reg;
    logic [`CORE_XLEN-1:0]   mem_alu, mem_store;
    logic [`CORE_REG_AW-1:0] mem_rd;
    logic                    wb_valid, wb_reg_w, wb_mem2reg, wb_we;
    logic [`CORE_XLEN-1:0]   wb_alu, wb_rdata, wb_result;
    logic [`CORE_REG_AW-1:0] wb_rd;

    // Hazard control
    logic mem_stall, load_use, redirect, fetch_stall, ex_load;

    assign f_rs1 = instr_q[19:15];
    assign f_rs2 = instr_q[24:20];
    assign f_rd  = instr_q[11:7];

    assign wb_we     = wb_valid && wb_reg_w;
    assign wb_result = wb_mem2reg ? wb_rdata : wb_alu;

    assign mem_stall   = (o_store_req || o_load_req) && !i_mem_ready;
    assign load_use    = f_valid && ex_valid && ex_mem2reg &&
                         (ex_rd == f_rs1 || ex_rd == f_rs2);
    assign redirect    = ex_valid && !mem_stall && (ex_jump || (ex_branch && ex_taken));
    assign fetch_stall = !i_if_valid || load_use || mem_stall;
    assign ex_load     = f_valid && !fetch_stall && !redirect && !dec_illegal;

    // Re-read the buffered instruction's sources while it waits
    assign rf_rs1_addr = fetch_stall ? f_rs1 : i_instr[19:15];
    assign rf_rs2_addr = fetch_stall ? f_rs2 : i_instr[24:20];

    function automatic fwd_sel_e pick_fwd(input logic [`CORE_REG_AW-1:0] src);
        if (mem_valid && mem_reg_w && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_we && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_rs1 = pick_fwd(ex_rs1_addr);
    assign fwd_rs2 = pick_fwd(ex_rs2_addr);

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_wr_en    (wb_we),
        .i_rd_addr  (wb_rd),
        .i_rd_data  (wb_result),
        .i_rs1_addr (rf_rs1_addr),
        .i_rs2_addr (rf_rs2_addr),
        .o_rs1_data (rf_rs1),
        .o_rs2_data (rf_rs2)
    );

    rv_decode u_decode (
        .i_instr   (instr_q),
        .o_imm     (dec_imm),
        .o_alu_op  (dec_alu_op),
        .o_src_a   (dec_src_a),
        .o_src_b   (dec_src_b),
        .o_reg_w   (dec_reg_w),
        .o_mem_w   (dec_mem_w),
        .o_mem2reg (dec_mem2reg),
        .o_branch  (dec_branch),
        .o_jump    (dec_jump),
        .o_illegal (dec_illegal)
    );

    rv_execute u_execute (
        .i_alu_op     (ex_alu_op),
        .i_src_a      (ex_src_a),
        .i_src_b      (ex_src_b),
        .i_fwd_rs1    (fwd_rs1),
        .i_fwd_rs2    (fwd_rs2),
        .i_rs1        (ex_rs1),
        .i_rs2        (ex_rs2),
        .i_mem_result (mem_alu),
        .i_wb_result  (wb_result),
        .i_pc         (ex_pc),
        .i_imm        (ex_imm),
        .i_jalr       (ex_jalr),
        .o_alu_out    (ex_alu_out),
        .o_store_data (ex_store_data),
        .o_target     (ex_target),
        .o_taken      (ex_taken)
    );

    // PC and fetch buffer
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q    <= `CORE_RESET_PC;
            f_valid <= 1'b0;
        end else if (redirect) begin
            pc_q    <= ex_target;
            f_valid <= 1'b0;
        end else if (!fetch_stall) begin
            pc_q    <= pc_q + 'd4;
            f_valid <= 1'b1;
            f_pc    <= pc_q;
            instr_q <= i_instr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ex_valid <= 1'b0;
        end else if (mem_stall) begin
            // Writeback leaves next cycle, keep what it was forwarding
            if (fwd_rs1 == FWD_WB) begin
                ex_rs1 <= wb_result;
            end
            if (fwd_rs2 == FWD_WB) begin
                ex_rs2 <= wb_result;
            end
        end else begin
            ex_valid    <= ex_load;
            ex_pc       <= f_pc;
            ex_imm      <= dec_imm;
            // The write landing at this edge was missed by the read
            ex_rs1      <= (wb_we && wb_rd == f_rs1) ? wb_result : rf_rs1;
            ex_rs2      <= (wb_we && wb_rd == f_rs2) ? wb_result : rf_rs2;
            ex_rs1_addr <= f_rs1;
            ex_rs2_addr <= f_rs2;
            ex_rd       <= f_rd;
            ex_alu_op   <= dec_alu_op;
            ex_src_a    <= dec_src_a;
            ex_src_b    <= dec_src_b;
            ex_reg_w    <= dec_reg_w && (f_rd != '0);
            ex_mem_w    <= dec_mem_w;
            ex_mem2reg  <= dec_mem2reg;
            ex_branch   <= dec_branch;
            ex_jump     <= dec_jump;
            ex_jalr     <= (opcode_e'(instr_q[6:0]) == OPC_JALR);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (!mem_stall) begin
                mem_valid   <= ex_valid;
                mem_alu     <= ex_alu_out;
                mem_store   <= ex_store_data;
                mem_rd      <= ex_rd;
                mem_reg_w   <= ex_reg_w;
                mem_mem_w   <= ex_mem_w;
                mem_mem2reg <= ex_mem2reg;
            end
            wb_valid   <= mem_valid && !mem_stall;
            wb_alu     <= mem_alu;
            wb_rdata   <= i_data_in;
            wb_rd      <= mem_rd;
            wb_reg_w   <= mem_reg_w;
            wb_mem2reg <= mem_mem2reg;
        end
    end

    assign o_pc        = pc_q;
    assign o_data_addr = mem_alu;
    assign o_data_out  = mem_store;
    assign o_store_req = mem_valid && mem_mem_w;
    assign o_load_req  = mem_valid && mem_mem2reg;

    a_one_req: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_store_req && o_load_req));

    a_req_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_store_req || o_load_req) && !i_mem_ready |=>
        (o_store_req || o_load_req) && $stable(o_data_addr));

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/10ps
`include "core_config.svh"

module rv_decode (
    input  logic [31:0]           i_instr,
    output logic [`CORE_XLEN-1:0] o_imm,
    output rv_pkg::alu_op_e       o_alu_op,
    output rv_pkg::src_a_e        o_src_a,
    output rv_pkg::src_b_e        o_src_b,
    output logic                  o_reg_w,
    output logic                  o_mem_w,
    output logic                  o_mem2reg,
    output logic                  o_branch,
    output logic                  o_jump,
    output logic                  o_illegal
);
    import rv_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;

    logic [`CORE_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{(`CORE_XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{(`CORE_XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{(`CORE_XLEN-13){i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{(`CORE_XLEN-21){i_instr[31]}}, i_instr[31], i_instr[19:12],
                    i_instr[20], i_instr[30:21], 1'b0};

    // Shared by OP and OP-IMM, alt picks SUB or SRA
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        o_imm     = '0;
        o_alu_op  = ALU_ADD;
        o_src_a   = SRC_A_RS1;
        o_src_b   = SRC_B_IMM;
        o_reg_w   = 1'b0;
        o_mem_w   = 1'b0;
        o_mem2reg = 1'b0;
        o_branch  = 1'b0;
        o_jump    = 1'b0;
        o_illegal = 1'b0;
        case (opcode_e'(i_instr[6:0]))
            OPC_LUI: begin
                o_imm    = imm_u;
                o_alu_op = ALU_PASS_B;
                o_reg_w  = 1'b1;
            end
            OPC_AUIPC: begin
                o_imm   = imm_u;
                o_src_a = SRC_A_PC;
                o_reg_w = 1'b1;
            end
            // PC with rs2 selects the link value PC + 4
            OPC_JAL, OPC_JALR: begin
                o_imm     = i_instr[3] ? imm_j : imm_i;
                o_src_a   = SRC_A_PC;
                o_src_b   = SRC_B_RS2;
                o_reg_w   = 1'b1;
                o_jump    = 1'b1;
                o_illegal = !i_instr[3] && (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                o_imm    = imm_b;
                o_src_b  = SRC_B_RS2;
                o_branch = 1'b1;
                case (funct3)
                    3'b000:  o_alu_op = ALU_EQ;
                    3'b001:  o_alu_op = ALU_NE;
                    3'b100:  o_alu_op = ALU_SLT;
                    3'b101:  o_alu_op = ALU_GE;
                    3'b110:  o_alu_op = ALU_SLTU;
                    3'b111:  o_alu_op = ALU_GEU;
                    default: o_illegal = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                o_imm     = imm_i;
                o_reg_w   = 1'b1;
                o_mem2reg = 1'b1;
                o_illegal = (funct3 != 3'b010);
            end
            OPC_STORE: begin
                o_imm     = imm_s;
                o_mem_w   = 1'b1;
                o_illegal = (funct3 != 3'b010);
            end
            OPC_OP_IMM: begin
                o_imm     = imm_i;
                o_alu_op  = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
                o_reg_w   = 1'b1;
                o_illegal = (funct3 == 3'b001 && funct7 != 7'b0000000) ||
                            (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0000000);
            end
            OPC_OP: begin
                o_src_b   = SRC_B_RS2;
                o_alu_op  = arith_op(funct3, funct7[5]);
                o_reg_w   = 1'b1;
                o_illegal = (funct7 != 7'b0000000) &&
                            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            default: o_illegal = 1'b1;
        endcase
        if (o_illegal) begin
            o_reg_w   = 1'b0;
            o_mem_w   = 1'b0;
            o_mem2reg = 1'b0;
            o_branch  = 1'b0;
            o_jump    = 1'b0;
        end
    end

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/10ps
`include "core_config.svh"

module rv_execute (
    input  rv_pkg::alu_op_e       i_alu_op,
    input  rv_pkg::src_a_e        i_src_a,
    input  rv_pkg::src_b_e        i_src_b,
    input  rv_pkg::fwd_sel_e      i_fwd_rs1,
    input  rv_pkg::fwd_sel_e      i_fwd_rs2,
    input  logic [`CORE_XLEN-1:0] i_rs1,
    input  logic [`CORE_XLEN-1:0] i_rs2,
    input  logic [`CORE_XLEN-1:0] i_mem_result,
    input  logic [`CORE_XLEN-1:0] i_wb_result,
    input  logic [`CORE_XLEN-1:0] i_pc,
    input  logic [`CORE_XLEN-1:0] i_imm,
    input  logic                  i_jalr,
    output logic [`CORE_XLEN-1:0] o_alu_out,
    output logic [`CORE_XLEN-1:0] o_store_data,
    output logic [`CORE_XLEN-1:0] o_target,
    output logic                  o_taken
);
    import rv_pkg::*;

    localparam int SHW = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0] rs1_f, rs2_f;
    logic [`CORE_XLEN-1:0] op_a, op_b;
    logic [`CORE_XLEN-1:0] tgt_sum;
    logic                  lt_s, lt_u, eq;

    // Memory stage is younger, so it wins over writeback
    always_comb begin
        case (i_fwd_rs1)
            FWD_MEM: rs1_f = i_mem_result;
            FWD_WB:  rs1_f = i_wb_result;
            default: rs1_f = i_rs1;
        endcase
        case (i_fwd_rs2)
            FWD_MEM: rs2_f = i_mem_result;
            FWD_WB:  rs2_f = i_wb_result;
            default: rs2_f = i_rs2;
        endcase
    end

    assign op_a = (i_src_a == SRC_A_PC) ? i_pc : rs1_f;

    // Jumps pair PC with rs2, which turns into the link offset
    assign op_b = (i_src_b == SRC_B_IMM) ? i_imm :
                  (i_src_a == SRC_A_PC)  ? 'd4 : rs2_f;

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;
    assign eq   = op_a == op_b;

    always_comb begin
        o_taken = 1'b0;
        case (i_alu_op)
            ALU_SUB:    o_alu_out = op_a - op_b;
            ALU_AND:    o_alu_out = op_a & op_b;
            ALU_OR:     o_alu_out = op_a | op_b;
            ALU_XOR:    o_alu_out = op_a ^ op_b;
            ALU_SLT:    o_alu_out = {{(`CORE_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   o_alu_out = {{(`CORE_XLEN-1){1'b0}}, lt_u};
            ALU_SLL:    o_alu_out = op_a << op_b[SHW-1:0];
            ALU_SRL:    o_alu_out = op_a >> op_b[SHW-1:0];
            ALU_SRA:    o_alu_out = $signed(op_a) >>> op_b[SHW-1:0];
            ALU_PASS_B: o_alu_out = op_b;
            ALU_EQ:     o_alu_out = {{(`CORE_XLEN-1){1'b0}}, eq};
            ALU_NE:     o_alu_out = {{(`CORE_XLEN-1){1'b0}}, !eq};
            ALU_GE:     o_alu_out = {{(`CORE_XLEN-1){1'b0}}, !lt_s};
            ALU_GEU:    o_alu_out = {{(`CORE_XLEN-1){1'b0}}, !lt_u};
            default:    o_alu_out = op_a + op_b;
        endcase
        case (i_alu_op)
            ALU_EQ, ALU_NE, ALU_GE, ALU_GEU, ALU_SLT, ALU_SLTU: o_taken = o_alu_out[0];
            default: o_taken = 1'b0;
        endcase
    end

    assign o_store_data = rs2_f;

    // Branch targets are even already, clearing bit 0 only matters for JALR
    assign tgt_sum  = (i_jalr ? rs1_f : i_pc) + i_imm;
    assign o_target = {tgt_sum[`CORE_XLEN-1:1], 1'b0};

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // SLT and SLTU also serve as the BLT and BLTU compares
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B,
        ALU_EQ,
        ALU_NE,
        ALU_GE,
        ALU_GEU
    } alu_op_e;

    typedef enum logic {SRC_A_RS1, SRC_A_PC} src_a_e;

    typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage

// File: hw/rv_regfile.sv
`timescale 1ns/10ps
`include "core_config.svh"

module rv_regfile (
    input  logic                    i_clk,
    input  logic                    i_wr_en,
    input  logic [`CORE_REG_AW-1:0] i_rd_addr,
    input  logic [`CORE_XLEN-1:0]   i_rd_data,
    input  logic [`CORE_REG_AW-1:0] i_rs1_addr,
    input  logic [`CORE_REG_AW-1:0] i_rs2_addr,
    output logic [`CORE_XLEN-1:0]   o_rs1_data,
    output logic [`CORE_XLEN-1:0]   o_rs2_data
);
    logic [`CORE_XLEN-1:0] regs [0:(1 << `CORE_REG_AW)-1];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // Registered read, a same-cycle write is returned instead of the old word
    always_ff @(posedge i_clk) begin
        o_rs1_data <= (i_rs1_addr == '0) ? '0 :
                      (i_wr_en && i_rd_addr == i_rs1_addr) ? i_rd_data : regs[i_rs1_addr];
        o_rs2_data <= (i_rs2_addr == '0) ? '0 :
                      (i_wr_en && i_rd_addr == i_rs2_addr) ? i_rd_data : regs[i_rs2_addr];
    end

    // The core drops x0 destinations before execute
    a_no_x0_write: assert property (@(posedge i_clk) i_wr_en |-> (i_rd_addr != '0));

endmodule

// File: include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data and address width, one word
`define CORE_XLEN 32

// Register address width, 32 registers
`define CORE_REG_AW 5

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: tb/tb_rv_core.sv
`timescale 1ns/10ps
`include "core_config.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int          NUM_INSTR = 64;
    localparam int          TIMEOUT   = NUM_INSTR * 20 + 200;
    localparam int          TAIL      = 20;
    localparam logic [31:0] END_PC    = NUM_INSTR * 4;

    logic                  i_clk = 1'b0;
    logic                  i_reset;
    logic [31:0]           i_instr;
    logic                  i_if_valid;
    logic [`CORE_XLEN-1:0] i_data_in;
    logic                  i_mem_ready;
    logic [`CORE_XLEN-1:0] o_pc, o_data_addr, o_data_out;
    logic                  o_store_req, o_load_req;

    logic [31:0] rom [0:127];
    logic [31:0] dmem [0:63];
    logic        targeted [0:127];

    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [31:0] exp_ld_addr [$];
    int          errors, model_stores, model_loads, dut_stores, dut_loads;

    always #5 i_clk = ~i_clk;

    rv_core i_dut (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_instr     (i_instr),
        .i_if_valid  (i_if_valid),
        .i_data_in   (i_data_in),
        .i_mem_ready (i_mem_ready),
        .o_pc        (o_pc),
        .o_data_addr (o_data_addr),
        .o_data_out  (o_data_out),
        .o_store_req (o_store_req),
        .o_load_req  (o_load_req)
    );

    // Instruction ROM answers the PC in the same cycle
    assign i_instr = rom[o_pc[8:2]];

    function automatic logic [31:0] fill_word(input int idx);
        return {8'(idx * 37), 8'(~idx), 8'(idx ^ 8'hc3), 8'(idx)};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input logic [6:0] opc);
        return {imm, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd,
                                          input logic [6:0] opc);
        return {imm, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OPC_JAL};
    endfunction

    // Forward target inside the program, never the final loop
    function automatic int pick_target(input int from);
        int t;
        t = from + 1 + $urandom % 8;
        if (t > NUM_INSTR - 1) begin
            t = NUM_INSTR - 1;
        end
        targeted[t] = 1'b1;
        return t;
    endfunction

    function automatic logic [31:0] arith_ref(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic build_program();
        int          i, k, t, rd, rs1, rs2, kind;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        // Unused ROM words are harmless ADDIs to x0
        for (k = 0; k < 128; k++) begin
            rom[k] = enc_i(12'(k), 0, 3'b000, 0, OPC_OP_IMM);
            targeted[k] = 1'b0;
        end
        i = 0;
        while (i < NUM_INSTR) begin
            rd   = 1 + $urandom % 7;
            rs1  = 1 + $urandom % 7;
            rs2  = 1 + $urandom % 7;
            f3   = 3'($urandom);
            imm  = 12'($urandom);
            alt  = 1'($urandom);
            kind = (i < 7) ? -1 : $urandom % 10;
            rom[i] = enc_i(imm, rs1, 3'b000, rd, OPC_OP_IMM);
            case (kind)
                // Seed x1 to x7 first
                -1: rom[i] = enc_i(imm, 0, 3'b000, i + 1, OPC_OP_IMM);
                0, 1: rom[i] = enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                     rs2, rs1, f3, rd);
                2: begin
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm = {1'b0, alt && f3 == 3'b101, 5'b0, imm[4:0]};
                    end
                    rom[i] = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
                end
                3: rom[i] = enc_u(20'($urandom), rd, alt ? OPC_LUI : OPC_AUIPC);
                4: rom[i] = enc_i(12'(($urandom % 64) * 4), 0, 3'b010, rd, OPC_LOAD);
                5, 6: rom[i] = enc_s(12'(($urandom % 64) * 4), rs2, 0);
                7: if (i < NUM_INSTR - 1) begin
                    t = pick_target(i);
                    rom[i] = enc_b(13'((t - i) * 4), rs2, rs1,
                                   (f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3);
                end
                8: if (i < NUM_INSTR - 1) begin
                    t = pick_target(i);
                    rom[i] = enc_j(21'((t - i) * 4), rd);
                end
                // LUI, ADDI, JALR; bit 0 of the sum must be dropped
                default: if (i + 3 < NUM_INSTR && !targeted[i + 1] && !targeted[i + 2]) begin
                    t = pick_target(i + 2);
                    rom[i]     = enc_u(20'd0, rs1, OPC_LUI);
                    rom[i + 1] = enc_i(12'(t * 4 + 1), rs1, 3'b000, rs1, OPC_OP_IMM);
                    rom[i + 2] = enc_i(12'd0, rs1, 3'b000, rd, OPC_JALR);
                    i += 2;
                end
            endcase
            i++;
        end
        rom[NUM_INSTR] = enc_j(21'd0, 0);
    endtask

    task automatic run_model();
        logic [31:0] xreg [0:31];
        logic [31:0] ref_mem [0:63];
        logic [31:0] pc, ins, a, b, res, addr, next_pc;
        logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
        logic [2:0]  f3;
        logic        wr;
        int          k, steps;
        for (k = 0; k < 32; k++) begin
            xreg[k] = '0;
        end
        for (k = 0; k < 64; k++) begin
            ref_mem[k] = fill_word(k);
        end
        pc = `CORE_RESET_PC;
        steps = 0;
        while (pc != END_PC && steps < 4 * NUM_INSTR) begin
            ins   = rom[pc[8:2]];
            f3    = ins[14:12];
            a     = xreg[ins[19:15]];
            b     = xreg[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_u = {ins[31:12], 12'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            res     = '0;
            wr      = 1'b1;
            next_pc = pc + 4;
            case (opcode_e'(ins[6:0]))
                OPC_LUI:   res = imm_u;
                OPC_AUIPC: res = pc + imm_u;
                OPC_JAL: begin
                    res     = pc + 4;
                    next_pc = pc + imm_j;
                end
                OPC_JALR: begin
                    res     = pc + 4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                OPC_BRANCH: begin
                    wr = 1'b0;
                    if (branch_ref(f3, a, b)) begin
                        next_pc = pc + imm_b;
                    end
                end
                OPC_LOAD: begin
                    addr = a + imm_i;
                    exp_ld_addr.push_back(addr);
                    res = ref_mem[addr[7:2]];
                end
                OPC_STORE: begin
                    wr   = 1'b0;
                    addr = a + imm_s;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                    ref_mem[addr[7:2]] = b;
                end
                OPC_OP:     res = arith_ref(f3, ins[30], a, b);
                OPC_OP_IMM: res = arith_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
                default:    wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                xreg[ins[11:7]] = res;
            end
            pc = next_pc;
            steps++;
        end
        if (pc != END_PC) begin
            errors++;
            $display("ERROR: reference model never reached the final loop");
        end
        model_stores = exp_st_addr.size();
        model_loads  = exp_ld_addr.size();
    endtask

    // A request with ready high here is taken at the next rising edge
    task automatic watch_bus();
        if (o_store_req && i_mem_ready) begin
            dut_stores++;
            if (exp_st_addr.size() == 0) begin
                errors++;
                $display("ERROR: store to %h at %0t not expected by the model", o_data_addr, $time);
            end else begin
                check_value("o_data_addr", exp_st_addr.pop_front(), o_data_addr);
                check_value("o_data_out", exp_st_data.pop_front(), o_data_out);
            end
            dmem[o_data_addr[7:2]] = o_data_out;
        end
        if (o_load_req && i_mem_ready) begin
            dut_loads++;
            if (exp_ld_addr.size() == 0) begin
                errors++;
                $display("ERROR: load from %h at %0t not expected by the model", o_data_addr, $time);
            end else begin
                check_value("o_data_addr", exp_ld_addr.pop_front(), o_data_addr);
            end
        end
    endtask

    initial begin
        int          k, cycle, tail;
        logic [31:0] prev_pc;
        logic        at_end, timed_out;
        void'($urandom(32'h10e216e9));
        errors      = 0;
        dut_stores  = 0;
        dut_loads   = 0;
        i_reset     = 1'b1;
        i_if_valid  = 1'b0;
        i_mem_ready = 1'b0;
        i_data_in   = '0;
        build_program();
        run_model();
        for (k = 0; k < 64; k++) begin
            dmem[k] = fill_word(k);
        end
        repeat (10) @(negedge i_clk);
        i_reset = 1'b0;
        // Idle after reset, nothing fetched yet
        repeat (2) begin
            check_value("o_pc", `CORE_RESET_PC, o_pc);
            check_value("o_store_req", 0, o_store_req);
            check_value("o_load_req", 0, o_load_req);
            @(negedge i_clk);
        end
        prev_pc   = `CORE_RESET_PC;
        at_end    = 1'b0;
        timed_out = 1'b0;
        tail      = 0;
        cycle     = 0;
        while (tail < TAIL && !timed_out) begin
            i_if_valid  = ($urandom % 4) != 0;
            i_mem_ready = ($urandom % 3) != 0;
            i_data_in   = dmem[o_data_addr[7:2]];
            watch_bus();
            // Only the final JAL jumps into END_PC from above it
            if (at_end) begin
                tail++;
            end else if (o_pc == END_PC && prev_pc != END_PC && prev_pc != END_PC - 4 &&
                         !o_store_req && !o_load_req) begin
                at_end = 1'b1;
            end
            prev_pc = o_pc;
            cycle++;
            timed_out = !at_end && cycle >= TIMEOUT;
            @(negedge i_clk);
        end
        if (timed_out) begin
            errors++;
            $display("ERROR: core hung, final loop not reached after %0d cycles", cycle);
        end else begin
            check_value("store count", model_stores, dut_stores);
            check_value("load count", model_loads, dut_loads);
        end
        $display("Errors: %0d, stores %0d of %0d, loads %0d of %0d", errors, dut_stores,
                 model_stores, dut_loads, model_loads);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
